/* include/alu_defines.svh */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// machine word
`define DATA_WIDTH 32

// width of the execute stage control code
`define ALU_CTRL_WIDTH 8

// multiplier, cycles from operand capture to ready
`define MUL_LATENCY 4

// divider, 32 restoring steps plus the sign fix-up cycle
`define DIV_CYCLES 33

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module executeStageTb --Mdir obj_dir -f sources.f

output=$(./obj_dir/VexecuteStageTb)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

/* sources.f */
+incdir+include
src/mipsDataPkg.sv
src/aluOpPkg.sv
src/mulDivIf.sv
src/executeAlu.sv
src/pipeMultiplier.sv
src/restoringDivider.sv
src/executeStage.sv
verification/executeChecker.sv
verification/executeStageTb.sv

/* src/aluOpPkg.sv */
`default_nettype none

`include "alu_defines.svh"

package aluOpPkg;

    typedef enum logic [`ALU_CTRL_WIDTH-1:0] {
        // passes srcA through
        ALU_NOP   = 8'h00,

        // logic
        ALU_AND   = 8'h01,
        ALU_OR    = 8'h02,
        ALU_NOR   = 8'h03,
        ALU_XOR   = 8'h04,

        // add, subtract and compare
        ALU_ADD   = 8'h10,
        ALU_ADDU  = 8'h11,
        ALU_SUB   = 8'h12,
        ALU_SUBU  = 8'h13,
        ALU_SLT   = 8'h14,
        ALU_SLTU  = 8'h15,

        // shifts, variable forms take the amount from srcA
        ALU_SLLV  = 8'h20,
        ALU_SRLV  = 8'h21,
        ALU_SRAV  = 8'h22,
        ALU_SLL   = 8'h23,
        ALU_SRL   = 8'h24,
        ALU_SRA   = 8'h25,

        // misc single cycle
        ALU_LUI   = 8'h30,
        ALU_CLO   = 8'h31,
        ALU_CLZ   = 8'h32,
        ALU_MOVN  = 8'h33,
        ALU_MOVZ  = 8'h34,

        // HI/LO moves
        ALU_MTHI  = 8'h40,
        ALU_MTLO  = 8'h41,
        ALU_MFHI  = 8'h42,
        ALU_MFLO  = 8'h43,

        // multiply and divide engines
        ALU_MULT  = 8'h50,
        ALU_MULTU = 8'h51,
        ALU_MUL   = 8'h52,
        ALU_MADD  = 8'h53,
        ALU_MADDU = 8'h54,
        ALU_MSUB  = 8'h55,
        ALU_MSUBU = 8'h56,
        ALU_DIV   = 8'h58,
        ALU_DIVU  = 8'h59,

        // traps, immediate forms get the sign-extended imm on srcB
        ALU_TEQ   = 8'h60,
        ALU_TNE   = 8'h61,
        ALU_TGE   = 8'h62,
        ALU_TGEU  = 8'h63,
        ALU_TLT   = 8'h64,
        ALU_TLTU  = 8'h65,
        ALU_TEQI  = 8'h68,
        ALU_TNEI  = 8'h69,
        ALU_TGEI  = 8'h6a,
        ALU_TGEIU = 8'h6b,
        ALU_TLTI  = 8'h6c,
        ALU_TLTIU = 8'h6d
    } aluOp_e;

endpackage

`default_nettype wire

/* src/executeAlu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module executeAlu (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  aluOpPkg::aluOp_e     aluControl,
    input  mipsDataPkg::word_t   srcA,
    input  mipsDataPkg::word_t   srcB,
    input  mipsDataPkg::shamt_t  shamt,
    output mipsDataPkg::word_t   aluOut,
    output logic                 overflow,
    output logic                 trap,
    output logic                 aluStall,
    mulDivIf.client              mulPort,
    mulDivIf.client              divPort
);
    import mipsDataPkg::*;
    import aluOpPkg::*;

    localparam int Msb = `DATA_WIDTH - 1;

    dword_t hiLo;
    dword_t hiLoNext;
    logic   hiLoWrite;
    logic   mulClass;
    logic   divClass;
    word_t  sum;
    word_t  diff;
    shamt_t varShamt;
    logic [$clog2(`DIV_CYCLES + 2)-1:0] stallCycles;

    function automatic word_t leadingZeros(input word_t value);
        word_t count;
        logic  found;
        count = '0;
        found = 1'b0;
        for (int i = Msb; i >= 0; i--) begin
            if (value[i]) begin
                found = 1'b1;
            end else if (!found) begin
                count = count + 1'b1;
            end
        end
        return count;
    endfunction

    assign mulClass = aluControl inside {ALU_MULT, ALU_MULTU, ALU_MUL, ALU_MADD,
                                         ALU_MADDU, ALU_MSUB, ALU_MSUBU};
    assign divClass = aluControl inside {ALU_DIV, ALU_DIVU};

    // engines see the operands directly, upstream holds them during the stall
    assign mulPort.start    = mulClass && !mulPort.ready && !flush;
    assign mulPort.signedOp = aluControl inside {ALU_MULT, ALU_MUL, ALU_MADD, ALU_MSUB};
    assign mulPort.opA      = srcA;
    assign mulPort.opB      = srcB;
    assign mulPort.abort    = flush;

    assign divPort.start    = divClass && !divPort.ready && !flush;
    assign divPort.signedOp = (aluControl == ALU_DIV);
    assign divPort.opA      = srcA;
    assign divPort.opB      = srcB;
    assign divPort.abort    = flush;

    assign aluStall = !flush && ((mulClass && !mulPort.ready) || (divClass && !divPort.ready));

    assign sum      = srcA + srcB;
    assign diff     = srcA - srcB;
    assign varShamt = srcA[$bits(shamt_t)-1:0];

    always_comb begin
        aluOut   = '0;
        overflow = 1'b0;
        case (aluControl)
            ALU_NOP:  aluOut = srcA;
            ALU_AND:  aluOut = srcA & srcB;
            ALU_OR:   aluOut = srcA | srcB;
            ALU_NOR:  aluOut = ~(srcA | srcB);
            ALU_XOR:  aluOut = srcA ^ srcB;
            ALU_ADD: begin
                aluOut   = sum;
                overflow = (srcA[Msb] == srcB[Msb]) && (sum[Msb] != srcA[Msb]);
            end
            ALU_ADDU: aluOut = sum;
            ALU_SUB: begin
                aluOut   = diff;
                overflow = (srcA[Msb] != srcB[Msb]) && (diff[Msb] != srcA[Msb]);
            end
            ALU_SUBU: aluOut = diff;
            ALU_SLT:  aluOut = word_t'($signed(srcA) < $signed(srcB));
            ALU_SLTU: aluOut = word_t'(srcA < srcB);
            ALU_SLLV: aluOut = srcB << varShamt;
            ALU_SRLV: aluOut = srcB >> varShamt;
            ALU_SRAV: aluOut = word_t'($signed(srcB) >>> varShamt);
            ALU_SLL:  aluOut = srcB << shamt;
            ALU_SRL:  aluOut = srcB >> shamt;
            ALU_SRA:  aluOut = word_t'($signed(srcB) >>> shamt);
            ALU_LUI:  aluOut = srcB << (`DATA_WIDTH / 2);
            ALU_CLO:  aluOut = leadingZeros(~srcA);
            ALU_CLZ:  aluOut = leadingZeros(srcA);
            ALU_MOVN: aluOut = (srcB != '0) ? srcA : '0;
            ALU_MOVZ: aluOut = (srcB == '0) ? srcA : '0;
            ALU_MFHI: aluOut = hiLo[2*`DATA_WIDTH-1:`DATA_WIDTH];
            ALU_MFLO: aluOut = hiLo[Msb:0];
            // only meaningful in the ready cycle, when the stall drops
            ALU_MUL:  aluOut = mulPort.result[Msb:0];
            default:  aluOut = '0;
        endcase
    end

    // srcB carries the sign-extended immediate for the I forms
    always_comb begin
        case (aluControl)
            ALU_TEQ,  ALU_TEQI:  trap = (srcA == srcB);
            ALU_TNE,  ALU_TNEI:  trap = (srcA != srcB);
            ALU_TGE,  ALU_TGEI:  trap = ($signed(srcA) >= $signed(srcB));
            ALU_TGEU, ALU_TGEIU: trap = (srcA >= srcB);
            ALU_TLT,  ALU_TLTI:  trap = ($signed(srcA) < $signed(srcB));
            ALU_TLTU, ALU_TLTIU: trap = (srcA < srcB);
            default:             trap = 1'b0;
        endcase
    end

    always_comb begin
        hiLoNext  = hiLo;
        hiLoWrite = 1'b0;
        case (aluControl)
            ALU_MULT, ALU_MULTU: begin
                hiLoNext  = mulPort.result;
                hiLoWrite = mulPort.ready;
            end
            ALU_MADD, ALU_MADDU: begin
                hiLoNext  = hiLo + mulPort.result;
                hiLoWrite = mulPort.ready;
            end
            ALU_MSUB, ALU_MSUBU: begin
                hiLoNext  = hiLo - mulPort.result;
                hiLoWrite = mulPort.ready;
            end
            ALU_DIV, ALU_DIVU: begin
                hiLoNext  = divPort.result;
                hiLoWrite = divPort.ready;
            end
            ALU_MTHI: begin
                hiLoNext  = {srcA, hiLo[Msb:0]};
                hiLoWrite = 1'b1;
            end
            ALU_MTLO: begin
                hiLoNext  = {hiLo[2*`DATA_WIDTH-1:`DATA_WIDTH], srcA};
                hiLoWrite = 1'b1;
            end
            default: begin
                hiLoNext  = hiLo;
                hiLoWrite = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hiLo <= '0;
        end else if (hiLoWrite && !flush) begin
            hiLo <= hiLoNext;
        end
    end

    // length of the current stall run
    always_ff @(posedge clk) begin
        if (reset || !aluStall) begin
            stallCycles <= '0;
        end else begin
            stallCycles <= stallCycles + 1'b1;
        end
    end

    // a flushed instruction must leave HI/LO alone
    assert property (@(posedge clk) disable iff (reset) flush |=> $stable(hiLo));

    // both engines must answer within the divider latency
    assert property (@(posedge clk) disable iff (reset)
        aluStall |-> stallCycles <= `DIV_CYCLES);

endmodule

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  aluOpPkg::aluOp_e     aluControl,
    input  mipsDataPkg::word_t   srcA,
    input  mipsDataPkg::word_t   srcB,
    input  mipsDataPkg::shamt_t  shamt,
    output mipsDataPkg::word_t   aluOut,
    output logic                 overflow,
    output logic                 trap,
    output logic                 aluStall
);

    // one link per arithmetic engine
    mulDivIf mulBus ();
    mulDivIf divBus ();

    executeAlu aluInst (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .aluControl (aluControl),
        .srcA       (srcA),
        .srcB       (srcB),
        .shamt      (shamt),
        .aluOut     (aluOut),
        .overflow   (overflow),
        .trap       (trap),
        .aluStall   (aluStall),
        .mulPort    (mulBus.client),
        .divPort    (divBus.client)
    );

    pipeMultiplier mulInst (
        .clk   (clk),
        .reset (reset),
        .port  (mulBus.engine)
    );

    restoringDivider divInst (
        .clk   (clk),
        .reset (reset),
        .port  (divBus.engine)
    );

endmodule

`default_nettype wire

/* src/mipsDataPkg.sv */
`default_nettype none

`include "alu_defines.svh"

package mipsDataPkg;

    // one operand or one result
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // product, {remainder, quotient} or {HI, LO}
    typedef logic [2*`DATA_WIDTH-1:0] dword_t;

    // shift amount, from the instruction or from rs
    typedef logic [$clog2(`DATA_WIDTH)-1:0] shamt_t;

endpackage

`default_nettype wire

/* src/mulDivIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface mulDivIf;
    import mipsDataPkg::*;

    // request side, held by the ALU until ready
    logic   start;
    logic   signedOp;
    word_t  opA;
    word_t  opB;
    logic   abort;

    // one-cycle completion pulse and its payload
    logic   ready;
    dword_t result;

    modport client (
        output start, signedOp, opA, opB, abort,
        input  ready, result
    );

    modport engine (
        input  start, signedOp, opA, opB, abort,
        output ready, result
    );

endinterface

`default_nettype wire

/* src/pipeMultiplier.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module pipeMultiplier (
    input logic      clk,
    input logic      reset,
    mulDivIf.engine  port
);
    import mipsDataPkg::*;

    localparam int CountWidth = $clog2(`MUL_LATENCY + 1);

    logic signed [`DATA_WIDTH:0]     extA;
    logic signed [`DATA_WIDTH:0]     extB;
    logic signed [2*`DATA_WIDTH+1:0] fullProduct;
    dword_t                          stage [`MUL_LATENCY];
    logic                            busy;
    logic [CountWidth-1:0]           remaining;
    logic                            capture;

    // one extra bit so a single signed multiply covers both modes
    assign extA = {port.signedOp & port.opA[`DATA_WIDTH-1], port.opA};
    assign extB = {port.signedOp & port.opB[`DATA_WIDTH-1], port.opB};
    assign fullProduct = extA * extB;

    assign capture = port.start && !busy && !port.abort;

    always_ff @(posedge clk) begin
        if (capture) begin
            stage[0] <= fullProduct[2*`DATA_WIDTH-1:0];
        end
        for (int i = 1; i < `MUL_LATENCY; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || port.abort) begin
            busy      <= 1'b0;
            remaining <= '0;
        end else if (capture) begin
            busy      <= 1'b1;
            remaining <= CountWidth'(`MUL_LATENCY - 1);
        end else if (busy) begin
            if (remaining == '0) begin
                busy <= 1'b0;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    assign port.ready  = busy && (remaining == '0);
    assign port.result = stage[`MUL_LATENCY-1];

    assert property (@(posedge clk) disable iff (reset) port.ready |=> !port.ready);

endmodule

`default_nettype wire

/* src/restoringDivider.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module restoringDivider (
    input logic      clk,
    input logic      reset,
    mulDivIf.engine  port
);
    import mipsDataPkg::*;

    localparam int Msb        = `DATA_WIDTH - 1;
    localparam int Steps      = `DATA_WIDTH;
    localparam int CountWidth = $clog2(`DIV_CYCLES);

    word_t                 magA;
    word_t                 magB;
    word_t                 divisor;
    word_t                 quotient;
    word_t                 remainder;
    logic                  quotNeg;
    logic                  remNeg;
    logic                  busy;
    logic                  capture;
    logic                  done;
    logic [CountWidth-1:0] step;
    logic [`DATA_WIDTH+1:0] trial;

    // magnitudes for signed division
    assign magA = (port.signedOp && port.opA[Msb]) ? -port.opA : port.opA;
    assign magB = (port.signedOp && port.opB[Msb]) ? -port.opB : port.opB;

    assign capture = port.start && !busy && !port.abort;
    assign done    = busy && (step == CountWidth'(Steps));

    // shift next dividend bit into the partial remainder, then try the subtract
    assign trial = {1'b0, remainder, quotient[Msb]} - {2'b00, divisor};

    always_ff @(posedge clk) begin
        if (capture) begin
            quotient  <= magA;
            remainder <= '0;
            divisor   <= magB;
            quotNeg   <= port.signedOp && (port.opA[Msb] ^ port.opB[Msb]);
            remNeg    <= port.signedOp && port.opA[Msb];
        end else if (busy && !done) begin
            if (!trial[`DATA_WIDTH+1]) begin
                remainder <= trial[Msb:0];
                quotient  <= {quotient[Msb-1:0], 1'b1};
            end else begin
                // restore, keep the shifted remainder
                remainder <= {remainder[Msb-1:0], quotient[Msb]};
                quotient  <= {quotient[Msb-1:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || port.abort) begin
            busy <= 1'b0;
            step <= '0;
        end else if (capture) begin
            busy <= 1'b1;
            step <= '0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            step <= step + 1'b1;
        end
    end

    // sign fix-up in the ready cycle, remainder follows the dividend
    assign port.ready  = done;
    assign port.result = {remNeg ? -remainder : remainder, quotNeg ? -quotient : quotient};

    assert property (@(posedge clk) disable iff (reset)
        (port.start && port.signedOp) |-> (port.opB != '0));

endmodule

`default_nettype wire

/* verification/executeChecker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module executeChecker (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  aluOpPkg::aluOp_e    aluControl,
    input  mipsDataPkg::word_t  srcA,
    input  mipsDataPkg::word_t  srcB,
    input  mipsDataPkg::shamt_t shamt,
    input  mipsDataPkg::word_t  aluOut,
    input  logic                overflow,
    input  logic                trap,
    input  logic                aluStall,
    output int                  errorCount,
    output int                  checkCount
);
    import mipsDataPkg::*;
    import aluOpPkg::*;

    dword_t modelHiLo;
    logic   inReset = 1'b0;
    int     mismatches = 0;
    int     otherErrors = 0;
    int     checks = 0;
    int     stallRun = 0;

    assign errorCount = mismatches + otherErrors;
    assign checkCount = checks;

    // run length of leading bits equal to bitValue
    function automatic word_t countLeading(input word_t value, input logic bitValue);
        int n;
        n = 0;
        while (n < `DATA_WIDTH && value[`DATA_WIDTH-1-n] == bitValue) begin
            n++;
        end
        return word_t'(n);
    endfunction

    // stall length set by the engine that the code uses
    function automatic int expectedStall(input aluOp_e op);
        if (op inside {ALU_MULT, ALU_MULTU, ALU_MUL, ALU_MADD, ALU_MADDU,
                       ALU_MSUB, ALU_MSUBU}) begin
            return `MUL_LATENCY;
        end else if (op inside {ALU_DIV, ALU_DIVU}) begin
            return `DIV_CYCLES;
        end
        return 0;
    endfunction

    function automatic void predictOutputs(
        input  aluOp_e op,
        input  word_t  a,
        input  word_t  b,
        input  shamt_t sh,
        input  dword_t hiLo,
        output word_t  out,
        output logic   ovf,
        output logic   trp,
        output dword_t hiLoNext
    );
        logic signed [63:0] wideA;
        logic signed [63:0] wideB;
        logic signed [63:0] quot;
        logic signed [63:0] rem;
        logic [32:0]        sum33;
        dword_t             prodS;
        dword_t             prodU;
        dword_t             divU;

        wideA = {{32{a[31]}}, a};
        wideB = {{32{b[31]}}, b};
        prodS = wideA * wideB;
        prodU = {32'h0, a} * {32'h0, b};
        quot  = '0;
        rem   = '0;
        divU  = '0;
        // 64-bit signed division keeps the most negative dividend well defined
        if (b != '0) begin
            quot = wideA / wideB;
            rem  = wideA % wideB;
            divU = {a % b, a / b};
        end
        sum33    = '0;
        out      = '0;
        ovf      = 1'b0;
        trp      = 1'b0;
        hiLoNext = hiLo;
        case (op)
            ALU_NOP:   out = a;
            ALU_AND:   out = a & b;
            ALU_OR:    out = a | b;
            ALU_NOR:   out = ~(a | b);
            ALU_XOR:   out = a ^ b;
            ALU_ADD: begin
                sum33 = {a[31], a} + {b[31], b};
                out   = sum33[31:0];
                ovf   = sum33[32] ^ sum33[31];
            end
            ALU_ADDU:  out = a + b;
            ALU_SUB: begin
                sum33 = {a[31], a} - {b[31], b};
                out   = sum33[31:0];
                ovf   = sum33[32] ^ sum33[31];
            end
            ALU_SUBU:  out = a - b;
            ALU_SLT:   out = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:  out = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:   out = b << sh;
            ALU_SRL:   out = b >> sh;
            ALU_SRA:   out = word_t'($signed(b) >>> sh);
            ALU_SLLV:  out = b << a[4:0];
            ALU_SRLV:  out = b >> a[4:0];
            ALU_SRAV:  out = word_t'($signed(b) >>> a[4:0]);
            ALU_LUI:   out = {b[15:0], 16'h0000};
            ALU_CLO:   out = countLeading(a, 1'b1);
            ALU_CLZ:   out = countLeading(a, 1'b0);
            ALU_MOVN:  out = (b != '0) ? a : '0;
            ALU_MOVZ:  out = (b == '0) ? a : '0;
            ALU_MFHI:  out = hiLo[63:32];
            ALU_MFLO:  out = hiLo[31:0];
            ALU_MUL:   out = prodS[31:0];
            ALU_MULT:  hiLoNext = prodS;
            ALU_MULTU: hiLoNext = prodU;
            ALU_MADD:  hiLoNext = hiLo + prodS;
            ALU_MADDU: hiLoNext = hiLo + prodU;
            ALU_MSUB:  hiLoNext = hiLo - prodS;
            ALU_MSUBU: hiLoNext = hiLo - prodU;
            ALU_DIV:   hiLoNext = {rem[31:0], quot[31:0]};
            ALU_DIVU:  hiLoNext = divU;
            ALU_MTHI:  hiLoNext = {a, hiLo[31:0]};
            ALU_MTLO:  hiLoNext = {hiLo[63:32], a};
            ALU_TEQ,  ALU_TEQI:  trp = (a == b);
            ALU_TNE,  ALU_TNEI:  trp = (a != b);
            ALU_TGE,  ALU_TGEI:  trp = !($signed(a) < $signed(b));
            ALU_TGEU, ALU_TGEIU: trp = !(a < b);
            ALU_TLT,  ALU_TLTI:  trp = ($signed(a) < $signed(b));
            ALU_TLTU, ALU_TLTIU: trp = (a < b);
            default:   out = '0;
        endcase
    endfunction

    always @(posedge clk) begin
        word_t  expOut;
        logic   expOvf;
        logic   expTrap;
        dword_t expHiLo;

        if (reset) begin
            modelHiLo = '0;
            inReset   = 1'b1;
            stallRun  = 0;
        end else begin
            if (inReset && aluStall) begin
                $display("ERROR: aluStall is still high after reset was released");
                otherErrors++;
            end
            inReset = 1'b0;
            if (flush && aluStall) begin
                $display("CHECK FAILED aluStall: expected %h, got %h in a flush cycle",
                         1'b0, aluStall);
                mismatches++;
            end
            // an operation completes on an edge with the stall low
            if (!aluStall) begin
                predictOutputs(aluControl, srcA, srcB, shamt, modelHiLo,
                               expOut, expOvf, expTrap, expHiLo);
                checks++;
                if (aluOut !== expOut) begin
                    $display("CHECK FAILED aluOut: expected %h, got %h (%s, srcA %h, srcB %h)",
                             expOut, aluOut, aluControl.name(), srcA, srcB);
                    mismatches++;
                end
                if (overflow !== expOvf) begin
                    $display("CHECK FAILED overflow: expected %h, got %h (%s, srcA %h, srcB %h)",
                             expOvf, overflow, aluControl.name(), srcA, srcB);
                    mismatches++;
                end
                if (trap !== expTrap) begin
                    $display("CHECK FAILED trap: expected %h, got %h (%s, srcA %h, srcB %h)",
                             expTrap, trap, aluControl.name(), srcA, srcB);
                    mismatches++;
                end
                // a flushed operation ends early
                if (!flush && stallRun != expectedStall(aluControl)) begin
                    $display("CHECK FAILED aluStall cycles: expected %h, got %h (%s)",
                             expectedStall(aluControl), stallRun, aluControl.name());
                    mismatches++;
                end
                stallRun = 0;
                if (!flush) begin
                    modelHiLo = expHiLo;
                end
            end else begin
                stallRun++;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/executeStageTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module executeStageTb;
    import mipsDataPkg::*;
    import aluOpPkg::*;

    // 2 reset reads, 64 arith, 60 shift/misc, 48 trap, 30 mul/div, 36 HI/LO, 9 flush
    localparam int TotalOps  = 249;
    localparam int TimeoutNs = TotalOps * (`DIV_CYCLES + 4) * 8 + 16 * 8 + 2000;

    localparam aluOp_e ArithOps [10] = '{ALU_AND, ALU_OR, ALU_NOR, ALU_XOR, ALU_ADD,
                                         ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU};
    localparam aluOp_e ShiftOps [12] = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV,
                                         ALU_SRAV, ALU_LUI, ALU_CLO, ALU_CLZ, ALU_MOVN,
                                         ALU_MOVZ, ALU_NOP};
    localparam aluOp_e TrapOps [12]  = '{ALU_TEQ, ALU_TNE, ALU_TGE, ALU_TGEU, ALU_TLT,
                                         ALU_TLTU, ALU_TEQI, ALU_TNEI, ALU_TGEI, ALU_TGEIU,
                                         ALU_TLTI, ALU_TLTIU};
    localparam aluOp_e MulDivOps [5] = '{ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU, ALU_MUL};
    localparam aluOp_e HiLoOps [6]   = '{ALU_MTHI, ALU_MTLO, ALU_MADD, ALU_MADDU,
                                         ALU_MSUB, ALU_MSUBU};

    logic   clk;
    logic   reset;
    logic   flush;
    aluOp_e aluControl;
    word_t  srcA;
    word_t  srcB;
    shamt_t shamt;
    word_t  aluOut;
    logic   overflow;
    logic   trap;
    logic   aluStall;
    int     errorCount;
    int     checkCount;
    word_t  lfsr = 32'hc719;

    always #4 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic word_t takeBits(input int count);
        word_t bits;
        logic  feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr     = {lfsr[30:0], feedback};
            bits     = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    // zero and all-ones words show up often
    function automatic word_t pickOperand();
        word_t kind;
        kind = takeBits(2);
        case (kind[1:0])
            2'b00:   return '0;
            2'b01:   return '1;
            default: return takeBits(32);
        endcase
    endfunction

    function automatic word_t signExtendImm(input word_t raw);
        return {{16{raw[15]}}, raw[15:0]};
    endfunction

    // inputs stay put until an edge with the stall low
    task automatic waitDone();
        do begin
            @(posedge clk);
        end while (aluStall);
        @(negedge clk);
    endtask

    task automatic runOp(input aluOp_e op, input word_t a, input word_t b, input shamt_t sh);
        aluControl = op;
        srcA       = a;
        srcB       = b;
        shamt      = sh;
        waitDone();
    endtask

    executeStage dut_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .aluControl (aluControl),
        .srcA       (srcA),
        .srcB       (srcB),
        .shamt      (shamt),
        .aluOut     (aluOut),
        .overflow   (overflow),
        .trap       (trap),
        .aluStall   (aluStall)
    );

    executeChecker checker_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .aluControl (aluControl),
        .srcA       (srcA),
        .srcB       (srcB),
        .shamt      (shamt),
        .aluOut     (aluOut),
        .overflow   (overflow),
        .trap       (trap),
        .aluStall   (aluStall),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    initial begin
        int     idx;
        aluOp_e op;
        word_t  a;
        word_t  b;

        clk        = 1'b0;
        reset      = 1'b1;
        flush      = 1'b0;
        aluControl = ALU_NOP;
        srcA       = '0;
        srcB       = '0;
        shamt      = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // HI/LO comes out of reset as zero
        runOp(ALU_MFHI, '0, '0, '0);
        runOp(ALU_MFLO, '0, '0, '0);

        // signed overflow corners
        runOp(ALU_ADD, 32'h7fffffff, 32'h00000001, '0);
        runOp(ALU_ADD, 32'h80000000, 32'hffffffff, '0);
        runOp(ALU_SUB, 32'h80000000, 32'h00000001, '0);
        runOp(ALU_SUB, 32'h7fffffff, 32'hffffffff, '0);
        repeat (60) begin
            idx = int'(takeBits(8) % 10);
            a   = pickOperand();
            b   = pickOperand();
            runOp(ArithOps[idx], a, b, shamt_t'(takeBits(5)));
        end

        repeat (60) begin
            idx = int'(takeBits(8) % 12);
            a   = pickOperand();
            b   = pickOperand();
            runOp(ShiftOps[idx], a, b, shamt_t'(takeBits(5)));
        end

        repeat (48) begin
            idx = int'(takeBits(8) % 12);
            op  = TrapOps[idx];
            a   = pickOperand();
            b   = pickOperand();
            if (op inside {ALU_TEQI, ALU_TNEI, ALU_TGEI, ALU_TGEIU, ALU_TLTI, ALU_TLTIU}) begin
                b = signExtendImm(takeBits(16));
            end
            // equal operands now and then
            if (takeBits(2) == '0) begin
                a = b;
            end
            runOp(op, a, b, '0);
        end

        for (int i = 0; i < 10; i++) begin
            a = takeBits(32);
            b = takeBits(32);
            if (b == '0) begin
                b = 32'd1;
            end
            runOp(MulDivOps[i % 5], a, b, '0);
            runOp(ALU_MFHI, '0, '0, '0);
            runOp(ALU_MFLO, '0, '0, '0);
        end

        for (int i = 0; i < 12; i++) begin
            a = pickOperand();
            b = pickOperand();
            runOp(HiLoOps[i % 6], a, b, '0);
            runOp(ALU_MFHI, '0, '0, '0);
            runOp(ALU_MFLO, '0, '0, '0);
        end

        // abort a divide partway, HI/LO must survive
        repeat (2) begin
            aluControl = ALU_DIV;
            srcA       = takeBits(32);
            srcB       = takeBits(32) | 32'd1;
            repeat (5) @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            runOp(ALU_MFHI, '0, '0, '0);
            runOp(ALU_MFLO, '0, '0, '0);
        end

        // the aborted divider takes a fresh request with full latency
        a = takeBits(32);
        b = takeBits(32) | 32'd1;
        runOp(ALU_DIVU, a, b, '0);
        runOp(ALU_MFHI, '0, '0, '0);
        runOp(ALU_MFLO, '0, '0, '0);

        repeat (2) @(negedge clk);
        $display("executeStageTb: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("ERROR: timeout after %0d ns, the DUT stopped completing operations",
                 TimeoutNs);
        $display("executeStageTb: %0d checks, %0d errors", checkCount, errorCount);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
